// ==== logic/alu_pipe_pkg.sv ====
/*
 * alu pipeline package
 * operand and tag widths, opcode encoding and the layouts
 * of the command and result words
 */
package alu_pipe_pkg;

  // operand and result width
  parameter int DATA_W = 8;
  // the sequence tag wraps back to 0 after 15
  parameter int SEQ_W = 4;
  // shift amount comes from the low bits of operand b
  parameter int SHAMT_W = $clog2(DATA_W);

  // ------------------------------------------------
  // opcodes
  // ------------------------------------------------
  // codes 8..15 are not defined and all decode to OP_ILL
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SHL  = 4'd5,
    OP_SHR  = 4'd6,
    OP_PASS = 4'd7,
    OP_ILL  = 4'd15
  } op_e;

  // ------------------------------------------------
  // command and result words
  // ------------------------------------------------
  // 20 bit command with the opcode still undecoded
  typedef struct packed {
    logic [3:0]        opcode;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
  } raw_cmd_t;

  // 15 bit result as seen on the result port
  typedef struct packed {
    logic [SEQ_W-1:0]  seq;
    logic              err;
    logic              carry;
    logic              zero;
    logic [DATA_W-1:0] value;
  } result_t;

endpackage

// ==== logic/dec_if.sv ====
/*
 * decode to execute link
 * one decoded operation and its operands, srdy/drdy handshake
 */
`timescale 1ns/1ps

interface dec_if import alu_pipe_pkg::*; ();

  // transfer when srdy and drdy are both high
  logic              srdy;
  logic              drdy;
  // decoded operation and operands
  op_e               op;
  logic [DATA_W-1:0] a;
  logic [DATA_W-1:0] b;

  // decode stage drives the operation
  modport src (output srdy, output op, output a, output b, input drdy);

  // execute stage only returns drdy
  modport dst (input srdy, input op, input a, input b, output drdy);

endinterface

// ==== logic/exec_if.sv ====
/*
 * execute to result link
 * raw alu value, carry and error bit, srdy/drdy handshake
 */
`timescale 1ns/1ps

interface exec_if import alu_pipe_pkg::*; ();

  // transfer when srdy and drdy are both high
  logic              srdy;
  logic              drdy;
  // alu outputs before flags and tag are added
  logic              op_err;
  logic              carry;
  logic [DATA_W-1:0] value;

  // execute stage drives the result
  modport src (output srdy, output op_err, output carry, output value, input drdy);

  // result stage only returns drdy
  modport dst (input srdy, input op_err, input carry, input value, output drdy);

endinterface

// ==== logic/cmd_fifo.sv ====
/*
 * compact srdy/drdy fifo
 * flop array of any depth (2 or more, power of two or not)
 * with registered p_srdy and a usage count of stored words
 */
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int width = 8,
  parameter int depth = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  // write side
  input  logic                         c_srdy,
  output logic                         c_drdy,
  input  logic [width-1:0]             c_data,
  // read side
  output logic                         p_srdy,
  input  logic                         p_drdy,
  output logic [width-1:0]             p_data,
  // number of words held including the head word
  output logic [$clog2(depth+1)-1:0]   usage
);

  localparam int asz = $clog2(depth);
  localparam int usz = $clog2(depth + 1);

  logic [width-1:0] mem [0:depth-1];
  logic [asz-1:0]   wrptr;
  logic [asz-1:0]   rdptr;
  logic [asz-1:0]   wrptr_p1;
  logic [asz-1:0]   rdptr_p1;
  logic             full;
  logic             wr_en;
  logic             rd_en;
  logic             nxt_p_srdy;

  // ------------------------------------------------
  // pointer and flag logic
  // ------------------------------------------------
  // pointers wrap explicitly so odd depths work
  assign wrptr_p1 = (wrptr == asz'(depth - 1)) ? '0 : wrptr + 1'b1;
  assign rdptr_p1 = (rdptr == asz'(depth - 1)) ? '0 : rdptr + 1'b1;

  assign full   = (usage == usz'(depth));
  assign c_drdy = !full;
  assign wr_en  = c_srdy && !full;
  assign rd_en  = p_srdy && p_drdy;

  // hold while stalled, raise once something is stored,
  // stay up across back-to-back reads while more than one word remains
  assign nxt_p_srdy = (p_srdy && !p_drdy) ||
                      (!p_srdy && (usage > 0)) ||
                      (p_srdy && p_drdy && (usage > 1));

  // ------------------------------------------------
  // control registers
  // ------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr  <= '0;
      rdptr  <= '0;
      usage  <= '0;
      p_srdy <= 1'b0;
    end
    else
    begin
      p_srdy <= nxt_p_srdy;
      if (wr_en)
        wrptr <= wrptr_p1;
      if (rd_en)
        rdptr <= rdptr_p1;
      // simultaneous read and write leaves the count alone
      if (wr_en && !rd_en)
        usage <= usage + 1'b1;
      else if (rd_en && !wr_en)
        usage <= usage - 1'b1;
    end
  end

  // storage array written at the tail pointer
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wrptr] <= c_data;
  end

  // head word straight from the flops
  assign p_data = mem[rdptr];

  // ------------------------------------------------
  // checks
  // ------------------------------------------------
  a_usage_bound: assert property (@(posedge clk) disable iff (reset)
    usage <= usz'(depth));

  // a stalled head word must not be overwritten by a later write
  a_head_stable: assert property (@(posedge clk) disable iff (reset)
    p_srdy && !p_drdy |=> $stable(p_data));

endmodule

// ==== logic/cmd_decode.sv ====
/*
 * decode stage
 * maps the raw opcode onto op_e, flags undefined codes as OP_ILL
 * and holds the operation in one register stage
 */
`timescale 1ns/1ps

module cmd_decode import alu_pipe_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  // from the command fifo
  input  logic     in_srdy,
  output logic     in_drdy,
  input  raw_cmd_t in_cmd,
  // to the execute stage
  dec_if.src       dec
);

  op_e  op_dec;
  logic load;

  // ------------------------------------------------
  // opcode mapping
  // ------------------------------------------------
  // top bit set means an undefined code 8..15
  always_comb
  begin
    if (in_cmd.opcode[3])
      op_dec = OP_ILL;
    else
      op_dec = op_e'({1'b0, in_cmd.opcode[2:0]});
  end

  // ------------------------------------------------
  // pipeline register
  // ------------------------------------------------
  // take a new word when empty or when the current one leaves now
  assign in_drdy = !dec.srdy || dec.drdy;
  assign load    = in_srdy && in_drdy;

  always_ff @(posedge clk)
  begin
    if (reset)
      dec.srdy <= 1'b0;
    else if (load)
      dec.srdy <= 1'b1;
    else if (dec.drdy)
      dec.srdy <= 1'b0;
  end

  // payload loads with each accepted command
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      dec.op <= op_dec;
      dec.a  <= in_cmd.a;
      dec.b  <= in_cmd.b;
    end
  end

  // a word stalled behind execute has to wait intact
  a_hold_stalled: assert property (@(posedge clk) disable iff (reset)
    dec.srdy && !dec.drdy |=> dec.srdy && $stable(dec.op) &&
                              $stable(dec.a) && $stable(dec.b));

endmodule

// ==== logic/alu_execute.sv ====
/*
 * execute stage
 * byte alu (add, sub, logic ops, shifts, pass) with carry out,
 * results held in one register stage
 */
`timescale 1ns/1ps

module alu_execute import alu_pipe_pkg::*; (
  input  logic clk,
  input  logic reset,
  // decoded operation in
  dec_if.dst   dec,
  // raw result out
  exec_if.src  ex
);

  logic [DATA_W-1:0]   alu_value;
  logic                alu_carry;
  logic                alu_err;
  logic [DATA_W:0]     sum;
  logic [SHAMT_W-1:0]  shamt;
  logic [2*DATA_W-1:0] shl_wide;
  logic [2*DATA_W-1:0] shr_wide;
  logic                load;

  // ------------------------------------------------
  // alu
  // ------------------------------------------------
  assign shamt = dec.b[SHAMT_W-1:0];

  // ninth bit of the sum is the add carry
  assign sum = {1'b0, dec.a} + {1'b0, dec.b};

  // widened shifts keep the last bit shifted out,
  // which lands just past the byte and is 0 for a zero shift
  assign shl_wide = {{DATA_W{1'b0}}, dec.a} << shamt;
  assign shr_wide = {dec.a, {DATA_W{1'b0}}} >> shamt;

  always_comb
  begin
    alu_value = '0;
    alu_carry = 1'b0;
    alu_err   = 1'b0;
    case (dec.op)
      OP_ADD:
      begin
        alu_value = sum[DATA_W-1:0];
        alu_carry = sum[DATA_W];
      end
      OP_SUB:
      begin
        alu_value = dec.a - dec.b;
        // borrow
        alu_carry = (dec.b > dec.a);
      end
      OP_AND:  alu_value = dec.a & dec.b;
      OP_OR:   alu_value = dec.a | dec.b;
      OP_XOR:  alu_value = dec.a ^ dec.b;
      OP_SHL:
      begin
        alu_value = shl_wide[DATA_W-1:0];
        alu_carry = shl_wide[DATA_W];
      end
      OP_SHR:
      begin
        alu_value = shr_wide[2*DATA_W-1:DATA_W];
        alu_carry = shr_wide[DATA_W-1];
      end
      OP_PASS: alu_value = dec.a;
      // OP_ILL leaves value and carry at 0
      default: alu_err = 1'b1;
    endcase
  end

  // ------------------------------------------------
  // pipeline register
  // ------------------------------------------------
  assign dec.drdy = !ex.srdy || ex.drdy;
  assign load     = dec.srdy && dec.drdy;

  always_ff @(posedge clk)
  begin
    if (reset)
      ex.srdy <= 1'b0;
    else if (load)
      ex.srdy <= 1'b1;
    else if (ex.drdy)
      ex.srdy <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      ex.value  <= alu_value;
      ex.carry  <= alu_carry;
      ex.op_err <= alu_err;
    end
  end

  // illegal ops must never leak a value downstream
  a_err_zero: assert property (@(posedge clk) disable iff (reset)
    ex.srdy && ex.op_err |-> (ex.value == '0) && !ex.carry);

endmodule

// ==== logic/result_pack.sv ====
/*
 * result stage
 * adds the zero flag and a running sequence tag to the alu
 * result and pushes the packed word into the result fifo
 */
`timescale 1ns/1ps

module result_pack import alu_pipe_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  // raw result in
  exec_if.dst     ex,
  // packed result out to the fifo
  output logic    r_srdy,
  input  logic    r_drdy,
  output result_t r_data
);

  logic [SEQ_W-1:0] seq;
  logic             push;

  // ------------------------------------------------
  // pass-through handshake
  // ------------------------------------------------
  // the result fifo is the register after this stage
  assign r_srdy  = ex.srdy;
  assign ex.drdy = r_drdy;
  assign push    = r_srdy && r_drdy;

  // ------------------------------------------------
  // word assembly
  // ------------------------------------------------
  always_comb
  begin
    r_data.seq   = seq;
    r_data.err   = ex.op_err;
    r_data.carry = ex.carry;
    r_data.zero  = (ex.value == '0);
    r_data.value = ex.value;
  end

  // tag counts accepted results and wraps
  always_ff @(posedge clk)
  begin
    if (reset)
      seq <= '0;
    else if (push)
      seq <= seq + 1'b1;
  end

  // a stalled or idle cycle keeps the tag so results stay numbered in order
  a_tag_on_push: assert property (@(posedge clk) disable iff (reset)
    !push |=> $stable(seq));

endmodule

// ==== logic/alu_pipe_top.sv ====
/*
 * alu command pipeline top
 * command fifo, decode, execute and result stages, result fifo
 * all linked by srdy/drdy
 */
`timescale 1ns/1ps

module alu_pipe_top import alu_pipe_pkg::*; #(
  parameter int CMD_DEPTH = 6,
  parameter int RES_DEPTH = 5
) (
  input  logic                           clk,
  input  logic                           reset,
  // command port
  input  logic                           cmd_srdy,
  output logic                           cmd_drdy,
  input  raw_cmd_t                       cmd_data,
  // result port
  output logic                           res_srdy,
  input  logic                           res_drdy,
  output result_t                        res_data,
  // fill level of the command queue
  output logic [$clog2(CMD_DEPTH+1)-1:0] cmd_usage
);

  // command queue to decode
  logic     q_srdy;
  logic     q_drdy;
  raw_cmd_t q_data;

  // result stage to result queue
  logic     r_srdy;
  logic     r_drdy;
  result_t  r_data;

  dec_if  dec ();
  exec_if ex ();

  // ------------------------------------------------
  // command queue
  // ------------------------------------------------
  cmd_fifo #(
    .width ($bits(raw_cmd_t)),
    .depth (CMD_DEPTH)
  ) u_cmd_q (
    .clk    (clk),
    .reset  (reset),
    .c_srdy (cmd_srdy),
    .c_drdy (cmd_drdy),
    .c_data (cmd_data),
    .p_srdy (q_srdy),
    .p_drdy (q_drdy),
    .p_data (q_data),
    .usage  (cmd_usage)
  );

  // ------------------------------------------------
  // pipeline stages
  // ------------------------------------------------
  cmd_decode u_decode (
    .clk     (clk),
    .reset   (reset),
    .in_srdy (q_srdy),
    .in_drdy (q_drdy),
    .in_cmd  (q_data),
    .dec     (dec.src)
  );

  alu_execute u_execute (
    .clk   (clk),
    .reset (reset),
    .dec   (dec.dst),
    .ex    (ex.src)
  );

  result_pack u_result (
    .clk    (clk),
    .reset  (reset),
    .ex     (ex.dst),
    .r_srdy (r_srdy),
    .r_drdy (r_drdy),
    .r_data (r_data)
  );

  // ------------------------------------------------
  // result queue
  // ------------------------------------------------
  // fill level of this queue is not brought out
  cmd_fifo #(
    .width ($bits(result_t)),
    .depth (RES_DEPTH)
  ) u_res_q (
    .clk    (clk),
    .reset  (reset),
    .c_srdy (r_srdy),
    .c_drdy (r_drdy),
    .c_data (r_data),
    .p_srdy (res_srdy),
    .p_drdy (res_drdy),
    .p_data (res_data),
    .usage  ()
  );

endmodule

// ==== verification/alu_pipe_tb.sv ====
/*
 * testbench for the alu command pipeline
 * directed opcodes, tag wrap, streaming, random back-pressure
 * and a fill-to-capacity run, all scored against a reference model
 */
`timescale 1ns/1ps

module alu_pipe_tb import alu_pipe_pkg::*; ();

  localparam int CMD_DEPTH  = 6;
  localparam int RES_DEPTH  = 5;
  localparam int CLK_PERIOD = 20;
  localparam int USAGE_W    = $clog2(CMD_DEPTH + 1);
  localparam logic [31:0] SEED = 32'd70;

  // the watchdog budget is built from these per-test command counts
  localparam int N_DIRECTED = 15;
  localparam int N_SEQ      = 40;
  localparam int N_STREAM   = 200;
  localparam int N_BP       = 150;
  localparam int N_FILL     = CMD_DEPTH + 2 + RES_DEPTH;
  localparam int TOTAL_CMDS = N_DIRECTED + N_SEQ + N_STREAM + N_BP + N_FILL;

  typedef logic [USAGE_W-1:0] usage_t;

  // how the result sink drives res_drdy
  typedef enum logic [1:0] {SINK_STOP, SINK_GO, SINK_RANDOM} sink_mode_e;

  logic       clk = 1'b0;
  logic       reset;
  logic       cmd_srdy;
  logic       cmd_drdy;
  raw_cmd_t   cmd_data;
  logic       res_srdy;
  logic       res_drdy;
  result_t    res_data;
  usage_t     cmd_usage;

  // scoreboard state
  result_t          exp_q[$];
  logic [SEQ_W-1:0] tb_seq = '0;
  int               accepted = 0;
  string            test_name = "reset";
  sink_mode_e       sink_mode = SINK_GO;
  logic [31:0]      cmd_rng = SEED;
  logic [31:0]      stall_rng = SEED ^ 32'h5bd1e995;

  alu_pipe_top #(
    .CMD_DEPTH (CMD_DEPTH),
    .RES_DEPTH (RES_DEPTH)
  ) uut (
    .clk       (clk),
    .reset     (reset),
    .cmd_srdy  (cmd_srdy),
    .cmd_drdy  (cmd_drdy),
    .cmd_data  (cmd_data),
    .res_srdy  (res_srdy),
    .res_drdy  (res_drdy),
    .res_data  (res_data),
    .cmd_usage (cmd_usage)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // reference model and random source
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // alu, flag and tag rules applied to one accepted command
  function automatic result_t expected_result(input raw_cmd_t c, input logic [SEQ_W-1:0] tag);
    result_t           r;
    int                a_i;
    int                b_i;
    int                sh;
    int                i;
    logic [DATA_W-1:0] v;
    logic              cy;
    a_i = int'(c.a);
    b_i = int'(c.b);
    sh  = b_i % 8;
    v   = '0;
    cy  = 1'b0;
    r   = '0;
    case (c.opcode)
      4'd0:
      begin
        v  = DATA_W'(a_i + b_i);
        cy = (a_i + b_i) > 255;
      end
      4'd1:
      begin
        v  = DATA_W'(a_i - b_i);
        cy = b_i > a_i;
      end
      4'd2: v = c.a & c.b;
      4'd3: v = c.a | c.b;
      4'd4: v = c.a ^ c.b;
      // shifts one bit at a time and carry keeps the last bit out
      4'd5:
      begin
        v = c.a;
        for (i = 0; i < sh; i++)
        begin
          cy = v[DATA_W-1];
          v  = {v[DATA_W-2:0], 1'b0};
        end
      end
      4'd6:
      begin
        v = c.a;
        for (i = 0; i < sh; i++)
        begin
          cy = v[0];
          v  = {1'b0, v[DATA_W-1:1]};
        end
      end
      4'd7: v = c.a;
      default: r.err = 1'b1;
    endcase
    r.seq   = tag;
    r.carry = cy;
    r.value = v;
    r.zero  = (v == '0);
    return r;
  endfunction

  // --------------------------------------------------
  // compare tasks
  // --------------------------------------------------
  task automatic check_result(input string name, input result_t want, input result_t got);
    if (got !== want)
    begin
      $display("[ERROR] %s: expected %h, actual %h", name, want, got);
      $display("  seq/err/carry/zero/value expected %0d/%b/%b/%b/%h, actual %0d/%b/%b/%b/%h",
               want.seq, want.err, want.carry, want.zero, want.value,
               got.seq, got.err, got.carry, got.zero, got.value);
      $display("Done: errors found");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_usage(input string name, input usage_t want, input usage_t got);
    if (got !== want)
    begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, want, got);
      $display("Done: errors found");
      $fatal(1, "usage mismatch");
    end
  endtask

  task automatic check_count(input string name, input int want, input int got);
    if (got != want)
    begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, want, got);
      $display("Done: errors found");
      $fatal(1, "count mismatch");
    end
  endtask

  // --------------------------------------------------
  // scoreboard
  // --------------------------------------------------
  // sampled mid low phase where inputs and outputs have settled
  // and a handshake seen now completes on the next rising edge
  always @(negedge clk)
  begin : scoreboard
    result_t want;
    #5;
    if (!reset)
    begin
      if (cmd_srdy && cmd_drdy)
      begin
        exp_q.push_back(expected_result(cmd_data, tb_seq));
        tb_seq   = tb_seq + 1'b1;
        accepted = accepted + 1;
      end
      if (res_srdy && res_drdy)
      begin
        if (exp_q.size() == 0)
        begin
          $display("result %h came out with no command outstanding", res_data);
          $display("Done: errors found");
          $fatal(1, "unexpected result");
        end
        else
        begin
          want = exp_q.pop_front();
          check_result(test_name, want, res_data);
        end
      end
    end
  end

  // result sink drives res_drdy
  initial
  begin : sink
    res_drdy = 1'b1;
    forever
    begin
      @(negedge clk);
      case (sink_mode)
        SINK_STOP: res_drdy = 1'b0;
        SINK_GO:   res_drdy = 1'b1;
        default:
        begin
          // stalls on about 3 cycles in 8
          stall_rng = xorshift32(stall_rng);
          res_drdy  = (stall_rng[2:0] > 3'd2);
        end
      endcase
    end
  end

  initial
  begin : watchdog
    #(TOTAL_CMDS * 20 * CLK_PERIOD + 2000);
    $display("watchdog expired at %0t, the pipeline stopped making progress", $time);
    $display("Done: errors found");
    $fatal(1, "timeout");
  end

  // --------------------------------------------------
  // stimulus helpers called on a falling edge
  // --------------------------------------------------
  // holds the command until taken and returns on the next falling edge
  task automatic send_cmd(input raw_cmd_t c);
    cmd_srdy = 1'b1;
    cmd_data = c;
    #5;
    while (!cmd_drdy)
    begin
      @(negedge clk);
      #5;
    end
    @(negedge clk);
  endtask

  task automatic idle_cycles(input int n);
    cmd_srdy = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic random_cmd(output raw_cmd_t c);
    cmd_rng = xorshift32(cmd_rng);
    // about one command in eight gets an undefined opcode
    if (cmd_rng[26:24] == 3'd0)
      c.opcode = {1'b1, cmd_rng[2:0]};
    else
      c.opcode = {1'b0, cmd_rng[2:0]};
    c.a = cmd_rng[15:8];
    c.b = cmd_rng[23:16];
  endtask

  // every accepted command has come back out
  task automatic wait_drain();
    cmd_srdy = 1'b0;
    while (exp_q.size() != 0)
      @(negedge clk);
    @(negedge clk);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin : main
    raw_cmd_t c;
    int       start;
    logic     full_seen;
    reset    = 1'b1;
    cmd_srdy = 1'b0;
    cmd_data = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_usage("reset_usage", '0, cmd_usage);
    if (!cmd_drdy || res_srdy)
    begin
      $display("after reset cmd_drdy should be high and res_srdy low");
      $display("Done: errors found");
      $fatal(1, "bad reset state");
    end

    // edge operands for every opcode plus two undefined codes
    test_name = "directed";
    send_cmd({4'd0, 8'hff, 8'h01});
    send_cmd({4'd0, 8'h12, 8'h34});
    send_cmd({4'd1, 8'h00, 8'h01});
    send_cmd({4'd1, 8'h05, 8'h05});
    send_cmd({4'd2, 8'hf0, 8'h3c});
    send_cmd({4'd3, 8'ha0, 8'h05});
    send_cmd({4'd4, 8'h5a, 8'h5a});
    send_cmd({4'd5, 8'h81, 8'h08});
    send_cmd({4'd5, 8'h03, 8'h07});
    send_cmd({4'd6, 8'hc0, 8'h07});
    send_cmd({4'd6, 8'h81, 8'hf8});
    send_cmd({4'd7, 8'h00, 8'h11});
    send_cmd({4'd7, 8'h7e, 8'h00});
    send_cmd({4'd8, 8'h33, 8'h44});
    send_cmd({4'd15, 8'hff, 8'hff});
    wait_drain();

    // tag wraps past 15 more than once
    test_name = "seq_wrap";
    repeat (N_SEQ)
    begin
      random_cmd(c);
      send_cmd(c);
    end
    wait_drain();

    test_name = "stream";
    repeat (N_STREAM)
    begin
      random_cmd(c);
      send_cmd(c);
    end
    wait_drain();

    test_name = "backpressure";
    sink_mode = SINK_RANDOM;
    repeat (N_BP)
    begin
      cmd_rng = xorshift32(cmd_rng);
      idle_cycles(int'(cmd_rng[4:3]));
      random_cmd(c);
      send_cmd(c);
    end
    sink_mode = SINK_GO;
    wait_drain();

    // with the sink stopped push until the command port refuses
    test_name = "fill";
    sink_mode = SINK_STOP;
    repeat (2) @(negedge clk);
    start     = accepted;
    full_seen = 1'b0;
    while (!full_seen)
    begin
      random_cmd(c);
      cmd_srdy = 1'b1;
      cmd_data = c;
      #5;
      if (!cmd_drdy)
        full_seen = 1'b1;
      @(negedge clk);
    end
    // keep offering the last word while nothing more may get in
    repeat (10) @(negedge clk);
    check_count("fill_count", N_FILL, accepted - start);
    check_usage("fill_usage", usage_t'(CMD_DEPTH), cmd_usage);
    cmd_srdy  = 1'b0;
    sink_mode = SINK_GO;
    wait_drain();
    repeat (2) @(negedge clk);
    check_usage("drain_usage", '0, cmd_usage);

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== alu_pipe_top.f ====
logic/alu_pipe_pkg.sv
logic/dec_if.sv
logic/exec_if.sv
logic/cmd_fifo.sv
logic/cmd_decode.sv
logic/alu_execute.sv
logic/result_pack.sv
logic/alu_pipe_top.sv
verification/alu_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run for the alu command pipeline

VERILATOR ?= verilator
TOP       := alu_pipe_tb
FILELIST  := alu_pipe_top.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
